// File: dv/keypad_calc_tb.sv
`timescale 1ns/1ns
`include "calc_params.svh"

module keypad_calc_tb;

    localparam int W              = `CALC_WIDTH;
    localparam int HOLD_CYCLES    = 40;             // key held down per press
    localparam int GAP_CYCLES     = 30;             // idle rows after each press
    localparam int NUM_ACTIONS    = 43 + 60 + 32 + 12 + 24;    // presses and bounces
    localparam int TIMEOUT_CYCLES = NUM_ACTIONS * (HOLD_CYCLES + GAP_CYCLES) + 200;
    localparam int K_ADD          = 3;              // key index is row*4+col
    localparam int K_SUB          = 7;
    localparam int K_MUL          = 11;
    localparam int K_EQUAL        = 12;
    localparam int K_IGNORE       = 14;
    localparam int K_NEG          = 15;

    logic         clk;
    logic         nRST;
    logic [3:0]   row_in;
    logic [3:0]   col_out;
    logic [W-1:0] result;
    logic         result_valid;
    logic         result_ready;

    logic         key_down;                         // keypad model key is closed
    logic [1:0]   key_row;
    logic [1:0]   key_col;
    logic [31:0]  key_rng;                          // key stream generator
    logic [31:0]  stall_rng;                        // result_ready generator
    int           stall_max;                        // longest result_ready low run
    int           stall_cnt;
    logic         valid_seen;                       // result_valid in the last cycle
    logic         stall_prev;                       // last negedge saw valid and not ready
    logic [W-1:0] held_result;
    logic [W-1:0] exp_q[$];                         // expected results in order
    logic [W-1:0] m_entry;                          // reference calculator state
    logic [W-1:0] m_acc;
    int           m_op;
    logic         m_pend;
    int           checks;
    int           errors;
    int           cycle_cnt;

    keypad_calc_top DUT (
        .clk          (clk),
        .nRST         (nRST),
        .row_in       (row_in),
        .col_out      (col_out),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int digit_key(input int d);
        if (d == 0) return 13;                      // bottom row second column
        return ((d - 1) / 3) * 4 + (d - 1) % 3;
    endfunction

    // layout 1 2 3 add / 4 5 6 sub / 7 8 9 mul / equal 0 ignore neg
    function automatic int key_digit(input int idx);
        case (idx)
            0:       return 1;
            1:       return 2;
            2:       return 3;
            4:       return 4;
            5:       return 5;
            6:       return 6;
            8:       return 7;
            9:       return 8;
            10:      return 9;
            default: return 0;                      // key 13
        endcase
    endfunction

    // any key but equal with about half digits
    function automatic int entry_key(input int r);
        case (r % 16)
            8, 9:    return K_ADD;
            10, 11:  return K_SUB;
            12, 13:  return K_MUL;
            14, 15:  return K_NEG;
            default: return digit_key((r / 16) % 10);
        endcase
    endfunction

    function automatic logic [W-1:0] fold(input int op, input logic [W-1:0] a,
                                          input logic [W-1:0] b);
        case (op)
            K_ADD:   return a + b;
            K_SUB:   return a - b;
            default: return a * b;                  // wraps at W bits
        endcase
    endfunction

    task automatic next_rand(output int r);
        key_rng = xorshift32(key_rng);
        r       = int'(key_rng[30:0]);              // kept non-negative
    endtask

    // reference calculator with left to right chaining
    task automatic model_key(input int idx);
        logic [W-1:0] val;
        val = m_pend ? fold(m_op, m_acc, m_entry) : m_entry;
        if (idx == K_EQUAL) begin
            m_acc   = val;
            m_entry = '0;
            m_pend  = 1'b0;
            exp_q.push_back(val);
        end else if (idx == K_NEG) begin
            m_entry = -m_entry;
        end else if (idx == K_ADD || idx == K_SUB || idx == K_MUL) begin
            m_acc   = val;
            m_op    = idx;
            m_pend  = 1'b1;
            m_entry = '0;
        end else if (idx != K_IGNORE) begin
            m_entry = m_entry * W'(10) + W'(key_digit(idx));
        end
    endtask

    // called on a rising edge and returns on one
    task automatic hold_key(input int idx, input int cycles);
        key_row  = 2'(idx / 4);
        key_col  = 2'(idx % 4);
        key_down = 1'b1;
        repeat (cycles) @(posedge clk);
        key_down = 1'b0;
    endtask

    task automatic press_key(input int idx);
        model_key(idx);
        hold_key(idx, HOLD_CYCLES);
        repeat (GAP_CYCLES) @(posedge clk);
    endtask

    // short closure always under the debounce length
    task automatic bounce_key();
        int len;
        int r;
        next_rand(r);
        len = 3 + r % (`DEBOUNCE_CYCLES - 4);
        next_rand(r);
        hold_key(digit_key(r % 10), len);
        repeat (20) @(posedge clk);
    endtask

    task automatic finish_test(input int num, input string name, input int c0, input int e0);
        while (exp_q.size() != 0) @(negedge clk);   // wait for results to drain
        @(posedge clk);
        $display("test %0d %s: %0d checks, %0d errors", num, name, checks - c0, errors - e0);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // keypad matrix pulls a row low only while its column is driven
    initial begin
        row_in = 4'hf;
        forever begin
            @(posedge clk);
            #1;
            if (key_down && !col_out[key_col]) row_in = ~(4'b0001 << key_row);
            else row_in = 4'hf;
        end
    end

    // result_ready stalls at random on each new result
    initial begin
        result_ready = 1'b1;
        stall_rng    = xorshift32(32'hf20);
        stall_cnt    = 0;
        valid_seen   = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (result_valid && (!valid_seen || result_ready)) begin
                stall_rng = xorshift32(stall_rng);
                stall_cnt = int'(stall_rng % 32'(stall_max + 1));
            end
            if (stall_cnt > 0) begin
                result_ready = 1'b0;
                stall_cnt--;
            end else begin
                result_ready = 1'b1;
            end
            valid_seen = result_valid;
        end
    end

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (nRST) begin
            checks++;
            assert ($countones(col_out) == 3) else begin
                errors++;
                $display("mismatch col_out: expected one low bit, actual 0x%h", col_out);
            end
        end
        if (nRST && stall_prev) begin
            checks++;
            assert (result_valid && result == held_result) else begin
                errors++;
                if (!result_valid) $display("result_valid dropped while result_ready was low");
                else $display("mismatch result: held 0x%h, now 0x%h", held_result, result);
            end
        end
        if (nRST && result_valid && result_ready) begin
            checks++;
            assert (exp_q.size() != 0) else begin
                errors++;
                $display("result 0x%h arrived with no result expected", result);
            end
            if (exp_q.size() != 0) begin
                held_result = exp_q.pop_front();
                assert (result == held_result) else begin
                    errors++;
                    $display("mismatch result: expected 0x%h, actual 0x%h", held_result, result);
                end
            end
        end
        stall_prev  = result_valid && !result_ready;
        held_result = result;
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run not finished after %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        int c0;
        int e0;
        int r;
        nRST      = 1'b0;
        key_down  = 1'b0;
        key_row   = 2'd0;
        key_col   = 2'd0;
        key_rng   = 32'hf20;
        stall_max = 12;                             // short stalls so keys never wait long
        checks    = 0;
        errors    = 0;
        m_entry   = '0;
        m_acc     = '0;
        m_op      = K_ADD;
        m_pend    = 1'b0;
        repeat (2) @(posedge clk);
        #1 nRST = 1'b1;
        checks += 2;
        assert (col_out == 4'b1110) else begin
            errors++;
            $display("mismatch col_out: expected 0xe, actual 0x%h", col_out);
        end
        assert (!result_valid) else begin
            errors++;
            $display("mismatch result_valid: expected 0x0, actual 0x%h", result_valid);
        end
        @(posedge clk);

        c0 = checks;
        e0 = errors;
        for (int n = 0; n < 6; n++) begin
            for (int i = 0; i < 6; i++) begin
                next_rand(r);
                press_key(digit_key(r % 10));       // six digits can pass 2**16
            end
            press_key(K_EQUAL);
        end
        press_key(K_EQUAL);                         // lone equal with no digits
        finish_test(1, "digit entry", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int n = 0; n < 5; n++) begin
            for (int i = 0; i < 11; i++) begin
                next_rand(r);
                press_key(entry_key(r));
            end
            press_key(K_EQUAL);
        end
        finish_test(2, "chained operators", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int n = 0; n < 4; n++) begin
            bounce_key();
            next_rand(r);
            press_key(digit_key(r % 10));
            bounce_key();
            next_rand(r);
            press_key(digit_key(r % 10));
            next_rand(r);
            press_key(digit_key(r % 10));
            press_key(K_IGNORE);
            bounce_key();
            press_key(K_EQUAL);
        end
        finish_test(3, "bounce rejection", c0, e0);

        c0 = checks;
        e0 = errors;
        for (int n = 0; n < 4; n++) begin
            next_rand(r);
            press_key(digit_key(r % 10));           // same digit twice
            press_key(digit_key(r % 10));
            press_key(K_EQUAL);
        end
        finish_test(4, "release qualification", c0, e0);

        c0 = checks;
        e0 = errors;
        stall_max = 100;                            // next key lands inside the stall
        for (int n = 0; n < 4; n++) begin
            for (int i = 0; i < 5; i++) begin
                next_rand(r);
                press_key(entry_key(r));
            end
            press_key(K_EQUAL);                     // never two equals in a row
        end
        finish_test(5, "result back-pressure", c0, e0);

        checks++;
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d expected results never arrived", exp_q.size());
        end
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: keypad_calc_top.f
+incdir+src
src/calc_pkg.sv
src/debounce_timer.sv
src/keypad_scanner.sv
src/calc_engine.sv
src/keypad_calc_top.sv
dv/keypad_calc_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f keypad_calc_top.f \
    --top-module keypad_calc_tb -o keypad_calc_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/keypad_calc_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test completed successfully"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: src/calc_engine.sv
`timescale 1ns/1ns
`include "calc_params.svh"

module calc_engine (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic                   key_valid,
    input  calc_pkg::key_event_t   key,
    output logic                   key_ready,
    output logic [`CALC_WIDTH-1:0] result,
    output logic                   result_valid,
    input  logic                   result_ready
);

    localparam int W = `CALC_WIDTH;

    logic [W-1:0]       entry;          // number being typed
    logic [W-1:0]       acc;            // left operand of the chain
    calc_pkg::calc_op_t pend_op;        // operator waiting for its right side
    logic               has_pending;
    logic [W-1:0]       chain_val;      // acc op entry, or entry alone
    logic               key_xfer;
    logic               res_xfer;

    function automatic logic [W-1:0] apply_op(input calc_pkg::calc_op_t op,
                                              input logic [W-1:0] a,
                                              input logic [W-1:0] b);
        logic [W-1:0] r;
        case (op)
            calc_pkg::OP_ADD: r = a + b;
            calc_pkg::OP_SUB: r = a - b;
            calc_pkg::OP_MUL: r = a * b;    // low W bits only
            default:          r = b;        // neg is never left pending
        endcase
        return r;
    endfunction

    // stall keys only while a result sits unclaimed
    assign key_ready = !(result_valid && !result_ready);
    assign key_xfer  = key_valid && key_ready;
    assign res_xfer  = result_valid && result_ready;
    assign chain_val = has_pending ? apply_op(pend_op, acc, entry) : entry;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            entry        <= '0;
            acc          <= '0;
            pend_op      <= calc_pkg::OP_ADD;
            has_pending  <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            if (res_xfer) begin
                result_valid <= 1'b0;   // an equal below may set it again
            end
            if (key_xfer) begin
                case (key.kind)
                    calc_pkg::KIND_DIGIT: begin
                        entry <= entry * W'(10) + W'(key.digit);
                    end
                    calc_pkg::KIND_OP: begin
                        if (key.op == calc_pkg::OP_NEG) begin
                            entry <= -entry;            // two's complement
                        end else begin
                            acc         <= chain_val;   // fold left to right
                            pend_op     <= key.op;
                            has_pending <= 1'b1;
                            entry       <= '0;
                        end
                    end
                    calc_pkg::KIND_EQUAL: begin
                        acc          <= chain_val;
                        entry        <= '0;
                        has_pending  <= 1'b0;
                        pend_op      <= calc_pkg::OP_ADD;
                        result_valid <= 1'b1;
                    end
                    default: ;                          // ignore key
                endcase
            end
        end
    end

    // result payload, loaded only on equal
    always_ff @(posedge clk) begin
        if (key_xfer && (key.kind == calc_pkg::KIND_EQUAL)) begin
            result <= chain_val;
        end
    end

    a_result_hold: assert property (@(posedge clk) disable iff (!nRST)
        result_valid && !result_ready |=> result_valid && $stable(result));

endmodule

// File: src/calc_params.svh
`ifndef CALC_PARAMS_SVH
`define CALC_PARAMS_SVH

// operand and result width, results wrap modulo 2**width
`define CALC_WIDTH 16

// stable cycles needed to accept a press or a release
`define DEBOUNCE_CYCLES 10

// timer counter width, must hold DEBOUNCE_CYCLES-1
`define DEBOUNCE_BITS 4

`endif

// File: src/calc_pkg.sv
package calc_pkg;

    // what a key stands for
    typedef enum logic [1:0] {
        KIND_DIGIT  = 2'd0,             // 0..9 entry
        KIND_OP     = 2'd1,             // add, sub, mul or neg
        KIND_EQUAL  = 2'd2,             // finish the chain
        KIND_IGNORE = 2'd3              // blank key, accepted and dropped
    } key_kind_t;

    // operator codes; add/sub/mul match the row of the right column
    typedef enum logic [1:0] {
        OP_ADD = 2'd0,                  // row 0, col 3
        OP_SUB = 2'd1,                  // row 1, col 3
        OP_MUL = 2'd2,                  // row 2, col 3
        OP_NEG = 2'd3                   // row 3, col 3, acts on entry only
    } calc_op_t;

    // one accepted key, 8 bits; unused fields stay zero
    typedef struct packed {
        key_kind_t  kind;               // digit / op / equal / ignore
        calc_op_t   op;                 // valid for KIND_OP only
        logic [3:0] digit;              // valid for KIND_DIGIT only
    } key_event_t;

endpackage

// File: src/debounce_timer.sv
`timescale 1ns/1ns
`include "calc_params.svh"

module debounce_timer (
    input  logic clk,
    input  logic nRST,
    input  logic run,                   // count while high, clear while low
    output logic done                   // debounce length reached
);

    localparam logic [`DEBOUNCE_BITS-1:0] LAST = `DEBOUNCE_BITS'(`DEBOUNCE_CYCLES - 1);

    logic [`DEBOUNCE_BITS-1:0] cnt;     // cycles seen with run high

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            cnt <= '0;
        end else if (!run) begin
            cnt <= '0;                  // any gap restarts the interval
        end else if (cnt != LAST) begin
            cnt <= cnt + 1'b1;          // holds at LAST, done stays up
        end
    end

    assign done = run && (cnt == LAST);

    // done only ever comes up at the end of an unbroken run interval
    a_done_after_full_run: assert property (@(posedge clk) disable iff (!nRST)
        $rose(done) |-> run && $past(run, `DEBOUNCE_CYCLES - 1));

endmodule

// File: src/keypad_calc_top.sv
`timescale 1ns/1ns
`include "calc_params.svh"

module keypad_calc_top (
    input  logic                   clk,
    input  logic                   nRST,
    input  logic [3:0]             row_in,          // active low rows
    output logic [3:0]             col_out,         // active low columns
    output logic [`CALC_WIDTH-1:0] result,
    output logic                   result_valid,
    input  logic                   result_ready
);

    logic                 debounce_run;
    logic                 debounce_done;
    logic                 key_valid;
    logic                 key_ready;
    calc_pkg::key_event_t key;

    keypad_scanner u_scanner (
        .clk           (clk),
        .nRST          (nRST),
        .row_in        (row_in),
        .col_out       (col_out),
        .debounce_run  (debounce_run),
        .debounce_done (debounce_done),
        .key_valid     (key_valid),
        .key           (key),
        .key_ready     (key_ready)
    );

    debounce_timer u_timer (
        .clk  (clk),
        .nRST (nRST),
        .run  (debounce_run),
        .done (debounce_done)
    );

    calc_engine u_engine (
        .clk          (clk),
        .nRST         (nRST),
        .key_valid    (key_valid),
        .key          (key),
        .key_ready    (key_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready)
    );

endmodule

// File: src/keypad_scanner.sv
`timescale 1ns/1ns

module keypad_scanner (
    input  logic                 clk,
    input  logic                 nRST,
    input  logic [3:0]           row_in,        // active low, pulled up
    output logic [3:0]           col_out,       // one column driven low
    output logic                 debounce_run,
    input  logic                 debounce_done,
    output logic                 key_valid,
    output calc_pkg::key_event_t key,
    input  logic                 key_ready
);

    typedef enum logic [2:0] {
        ST_IDLE_START,                  // out of reset with column 0 driven
        ST_SCAN,                        // walk columns until a row reads low
        ST_QUALIFY,                     // hold column, wait for stable press
        ST_PRESENT,                     // key event offered to the engine
        ST_RELEASE_WAIT                 // wait for stable all-high rows
    } scan_state_t;

    scan_state_t state, state_nxt;
    logic [1:0]  col_idx;               // column being driven low
    logic        any_low;               // some row pulled down

    // lowest low row wins and row*4+col picks the key
    function automatic calc_pkg::key_event_t encode_key(input logic [3:0] rows,
                                                        input logic [1:0] col);
        calc_pkg::key_event_t ev;
        logic [1:0]           r;
        ev = '0;
        r  = 2'd3;
        for (int i = 3; i >= 0; i--) begin
            if (!rows[i]) r = 2'(i);    // last hit is the lowest row
        end
        if (col == 2'd3) begin
            ev.kind = calc_pkg::KIND_OP;           // add/sub/mul/neg column
            ev.op   = calc_pkg::calc_op_t'(r);
        end else if (r != 2'd3) begin
            ev.kind  = calc_pkg::KIND_DIGIT;       // 1..9 block
            ev.digit = ({2'b00, r} * 4'd3) + {2'b00, col} + 4'd1;
        end else begin
            case (col)
                2'd0:    ev.kind = calc_pkg::KIND_EQUAL;
                2'd1:    ev.kind = calc_pkg::KIND_DIGIT;   // digit 0 leaves the field at zero
                default: ev.kind = calc_pkg::KIND_IGNORE;
            endcase
        end
        return ev;
    endfunction

    assign any_low   = (row_in != 4'b1111);
    assign col_out   = ~(4'b0001 << col_idx);
    assign key_valid = (state == ST_PRESENT);

    // timer runs on a held press in qualify, on idle rows in release_wait
    assign debounce_run = ((state == ST_QUALIFY) && any_low) ||
                          ((state == ST_RELEASE_WAIT) && !any_low);

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE_START:   state_nxt = ST_SCAN;
            ST_SCAN:         if (any_low) state_nxt = ST_QUALIFY;
            ST_QUALIFY: begin
                if (!any_low)          state_nxt = ST_SCAN;      // bounce so start over
                else if (debounce_done) state_nxt = ST_PRESENT;
            end
            ST_PRESENT:      if (key_ready) state_nxt = ST_RELEASE_WAIT;
            ST_RELEASE_WAIT: if (debounce_done) state_nxt = ST_SCAN;
            default:         state_nxt = ST_IDLE_START;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state   <= ST_IDLE_START;
            col_idx <= 2'd0;
        end else begin
            state <= state_nxt;
            if ((state == ST_SCAN) && !any_low) begin
                col_idx <= col_idx + 2'd1;  // wraps 3 -> 0
            end
        end
    end

    // key payload is captured once when the press qualifies
    always_ff @(posedge clk) begin
        if ((state == ST_QUALIFY) && any_low && debounce_done) begin
            key <= encode_key(row_in, col_idx);
        end
    end

    // offered key holds until the engine takes it
    a_key_hold: assert property (@(posedge clk) disable iff (!nRST)
        key_valid && !key_ready |=> key_valid && $stable(key));

endmodule
